// ==== allocator/fit_search.sv ====
`default_nettype none

module fit_search (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              clear_i,
  input  wire logic                              hdr_valid_i,
  input  wire falafel_pkg::header_t              hdr_i,
  input  wire logic [falafel_pkg::DATA_W-1:0]    size_i,
  output falafel_pkg::fit_result_t               fit_o
);

  logic                           found_q;
  falafel_pkg::header_t           prev_q;
  falafel_pkg::header_t           best_q;
  falafel_pkg::header_t           best_prev_q;
  logic [falafel_pkg::DATA_W-1:0] diff_q;

  logic                           fits;
  logic                           better;
  logic [falafel_pkg::DATA_W-1:0] diff;

  assign fits = (hdr_i.size >= size_i);
  assign diff = hdr_i.size - size_i;
  // strictly smaller keeps the earliest block on a tie
  assign better = fits && (!found_q || (diff < diff_q));

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      found_q <= 1'b0;
    end else if (clear_i) begin
      found_q <= 1'b0;
    end else if (hdr_valid_i && better) begin
      found_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      prev_q <= '0;
    end else if (hdr_valid_i) begin
      prev_q <= hdr_i;  // header walked just before the next one
    end
  end

  always_ff @(posedge clk_i) begin
    if (hdr_valid_i && better && !clear_i) begin
      best_q      <= hdr_i;
      best_prev_q <= prev_q;
      diff_q      <= diff;
    end
  end

  assign fit_o.found     = found_q;
  assign fit_o.best      = best_q;
  assign fit_o.best_prev = best_prev_q;

endmodule

`default_nettype wire

// ==== allocator/lsu_sequencer.sv ====
`default_nettype none

module lsu_sequencer (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              req_valid_i,
  input  wire falafel_pkg::alloc_cmd_t           cmd_i,
  input  wire logic                              cmd_valid_i,
  input  wire falafel_pkg::fit_result_t          fit_i,
  input  wire falafel_pkg::write_plan_t          plan_i,
  input  wire logic                              lsu_ready_i,
  input  wire falafel_pkg::header_rsp_t          rsp_i,
  output logic                                   accept_o,
  output logic                                   core_ready_o,
  output falafel_pkg::header_req_t               req_o,
  output logic                                   walk_clear_o,
  output logic                                   hdr_valid_o,
  output falafel_pkg::header_t                   hdr_o,
  output logic                                   done_o,
  output logic [falafel_pkg::DATA_W-1:0]         alloc_addr_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_CMD,
    S_REQ,
    S_WAIT_RSP,
    S_PLAN,
    S_DONE
  } state_e;

  // which LSU request is issued from S_REQ
  typedef enum logic [2:0] {
    STEP_LOCK,
    STEP_LOAD,
    STEP_ALLOC,
    STEP_NEW,
    STEP_LINK,
    STEP_UNLOCK
  } step_e;

  state_e                         state_d, state_q;
  step_e                          step_d, step_q;
  logic [falafel_pkg::DATA_W-1:0] load_addr_d, load_addr_q;
  logic [falafel_pkg::DATA_W-1:0] result_d, result_q;
  logic                           last_hdr;

  assign core_ready_o = (state_q == S_IDLE);
  assign accept_o     = req_valid_i && core_ready_o;
  assign done_o       = (state_q == S_DONE);
  assign alloc_addr_o = result_q;

  assign hdr_valid_o  = (state_q == S_WAIT_RSP) && rsp_i.val && (step_q == STEP_LOAD);
  assign hdr_o        = rsp_i.header;
  assign last_hdr     = (rsp_i.header.next_addr == '0);
  assign walk_clear_o = (state_q == S_WAIT_CMD) && cmd_valid_i && !cmd_i.reject;

  always_comb begin
    req_o     = '0;
    req_o.val = (state_q == S_REQ);
    unique case (step_q)
      STEP_LOCK: req_o.lsu_op = falafel_pkg::LOCK;
      STEP_LOAD: begin
        req_o.lsu_op      = falafel_pkg::LOAD;
        req_o.header.addr = load_addr_q;
      end
      STEP_ALLOC: begin
        req_o.lsu_op = falafel_pkg::EDIT_SIZE_AND_NEXT_ADDR;
        req_o.header = plan_i.alloc_hdr;
      end
      STEP_NEW: begin
        req_o.lsu_op = falafel_pkg::EDIT_SIZE_AND_NEXT_ADDR;
        req_o.header = plan_i.new_hdr;
      end
      STEP_LINK: begin
        req_o.lsu_op = falafel_pkg::EDIT_NEXT_ADDR;
        req_o.header = plan_i.link_hdr;
      end
      STEP_UNLOCK: req_o.lsu_op = falafel_pkg::UNLOCK;
      default: ;
    endcase
  end

  always_comb begin
    state_d     = state_q;
    step_d      = step_q;
    load_addr_d = load_addr_q;
    result_d    = result_q;

    unique case (state_q)
      S_IDLE: if (accept_o) state_d = S_WAIT_CMD;
      S_WAIT_CMD: begin
        if (cmd_valid_i) begin
          if (cmd_i.reject) begin
            result_d = '0;  // no LSU traffic at all
            state_d  = S_DONE;
          end else begin
            step_d  = STEP_LOCK;
            state_d = S_REQ;
          end
        end
      end
      S_REQ: if (lsu_ready_i) state_d = S_WAIT_RSP;
      S_WAIT_RSP: begin
        if (rsp_i.val) begin
          state_d = S_REQ;
          unique case (step_q)
            STEP_LOCK: begin
              step_d      = STEP_LOAD;
              load_addr_d = falafel_pkg::HEAD_ADDR;
            end
            STEP_LOAD: begin
              if (last_hdr) begin
                state_d = S_PLAN;  // fit result settles next cycle
              end else begin
                load_addr_d = rsp_i.header.next_addr;
              end
            end
            STEP_ALLOC:  step_d = STEP_NEW;
            STEP_NEW:    step_d = STEP_LINK;
            STEP_LINK:   step_d = STEP_UNLOCK;
            STEP_UNLOCK: state_d = S_DONE;
            default: ;
          endcase
        end
      end
      S_PLAN: begin
        state_d  = S_REQ;
        result_d = fit_i.found ? fit_i.best.addr : '0;
        if (!fit_i.found) begin
          step_d = STEP_UNLOCK;  // nothing fits so only unlock
        end else if (plan_i.split) begin
          step_d = STEP_ALLOC;
        end else begin
          step_d = STEP_LINK;
        end
      end
      S_DONE: state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= S_IDLE;
      step_q  <= STEP_LOCK;
    end else begin
      state_q <= state_d;
      step_q  <= step_d;
    end
  end

  always_ff @(posedge clk_i) begin
    load_addr_q <= load_addr_d;
    result_q    <= result_d;
  end

  // plan_i feeds the write requests so the search result must hold too
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o.val && !lsu_ready_i |=> $stable(req_o));

  rsp_expected_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.val |-> state_q == S_WAIT_RSP);

endmodule

`default_nettype wire

// ==== allocator/split_planner.sv ====
`default_nettype none

module split_planner (
  input  wire falafel_pkg::fit_result_t          fit_i,
  input  wire logic [falafel_pkg::DATA_W-1:0]    size_i,
  output falafel_pkg::write_plan_t               plan_o
);

  logic [falafel_pkg::DATA_W:0]   need;  // wide so a huge request cannot wrap
  logic [falafel_pkg::DATA_W-1:0] new_addr;
  logic [falafel_pkg::DATA_W-1:0] new_size;
  logic                           split;

  assign need = {1'b0, size_i} + {1'b0, falafel_pkg::HEADER_SIZE}
              + {1'b0, falafel_pkg::MIN_ALLOC_SIZE};

  assign split = fit_i.found && ({1'b0, fit_i.best.size} >= need);

  // leftover block starts right after the allocated payload
  assign new_addr = fit_i.best.addr + falafel_pkg::HEADER_SIZE + size_i;
  assign new_size = fit_i.best.size - size_i - falafel_pkg::HEADER_SIZE;

  always_comb begin
    plan_o.split = split;

    // allocated block shrinks to the request and leaves the list
    plan_o.alloc_hdr.addr      = fit_i.best.addr;
    plan_o.alloc_hdr.size      = size_i;
    plan_o.alloc_hdr.next_addr = '0;

    plan_o.new_hdr.addr      = new_addr;
    plan_o.new_hdr.size      = new_size;
    plan_o.new_hdr.next_addr = fit_i.best.next_addr;

    // only next_addr of the previous header is written
    plan_o.link_hdr.addr = fit_i.best_prev.addr;
    plan_o.link_hdr.size = fit_i.best_prev.size;
    if (split) begin
      plan_o.link_hdr.next_addr = new_addr;
    end else begin
      plan_o.link_hdr.next_addr = fit_i.best.next_addr;  // skip the whole block
    end
  end

endmodule

`default_nettype wire

// ==== common/falafel_pkg.sv ====
`default_nettype none

package falafel_pkg;

  localparam int DATA_W = 32;

  // bytes in front of every block
  localparam logic [DATA_W-1:0] HEADER_SIZE    = 32'd16;
  localparam logic [DATA_W-1:0] MIN_ALLOC_SIZE = 32'd32;  // smallest leftover worth a split
  localparam logic [DATA_W-1:0] ALLOC_ALIGN    = 32'd8;
  localparam logic [DATA_W-1:0] ALIGN_MASK     = ~(ALLOC_ALIGN - 32'd1);

  // sentinel header has size zero so it never fits
  localparam logic [DATA_W-1:0] HEAD_ADDR = 32'h10;

  typedef struct packed {
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] size;
    logic [DATA_W-1:0] next_addr;
  } header_t;

  typedef enum logic [2:0] {
    LOCK,
    UNLOCK,
    LOAD,
    EDIT_SIZE_AND_NEXT_ADDR,
    EDIT_NEXT_ADDR
  } lsu_op_e;

  typedef struct packed {
    logic    val;
    lsu_op_e lsu_op;
    header_t header;
  } header_req_t;

  // LOAD answers carry the header and other ops only val
  typedef struct packed {
    logic    val;
    header_t header;
  } header_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] size;  // already aligned
    logic              reject;
  } alloc_cmd_t;

  typedef struct packed {
    logic    found;
    header_t best;
    header_t best_prev;
  } fit_result_t;

  typedef struct packed {
    logic    split;
    header_t alloc_hdr;
    header_t new_hdr;
    header_t link_hdr;
  } write_plan_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --timescale 1ns/1ps --top-module falafel_tb \
  -f src.f -o falafel_sim \
  && ./obj_dir/falafel_sim | tee sim.log \
  && ! grep -q "TEST FAIL" sim.log \
  && grep -q "TEST PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== source/alloc_req_decode.sv ====
`default_nettype none

module alloc_req_decode (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              req_valid_i,
  input  wire logic [falafel_pkg::DATA_W-1:0]    req_size_i,
  input  wire logic                              accept_i,
  output falafel_pkg::alloc_cmd_t                cmd_o,
  output logic                                   cmd_valid_o
);

  logic                           take;
  logic [falafel_pkg::DATA_W:0]   size_sum;  // carry bit catches overflow
  logic [falafel_pkg::DATA_W-1:0] size_aligned;
  logic                           size_bad;

  assign take = req_valid_i && accept_i;

  assign size_sum     = {1'b0, req_size_i} + {1'b0, falafel_pkg::ALLOC_ALIGN - 32'd1};
  assign size_aligned = size_sum[falafel_pkg::DATA_W-1:0] & falafel_pkg::ALIGN_MASK;
  assign size_bad     = (req_size_i == '0) || size_sum[falafel_pkg::DATA_W];

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= take;
    end
  end

  // held until the next accepted request
  always_ff @(posedge clk_i) begin
    if (take) begin
      cmd_o.size   <= size_aligned;
      cmd_o.reject <= size_bad;
    end
  end

  // the sequencer drops ready right after it takes a request
  cmd_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

`default_nettype wire

// ==== source/falafel_core.sv ====
`default_nettype none

module falafel_core (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              req_valid_i,
  input  wire logic [falafel_pkg::DATA_W-1:0]    req_size_i,
  output logic                                   core_ready_o,
  output logic                                   done_o,
  output logic [falafel_pkg::DATA_W-1:0]         alloc_addr_o,
  output falafel_pkg::header_req_t               req_to_lsu_o,
  input  wire logic                              lsu_ready_i,
  input  wire falafel_pkg::header_rsp_t          rsp_from_lsu_i
);

  falafel_pkg::alloc_cmd_t  cmd;
  logic                     cmd_valid;
  logic                     accept;
  logic                     walk_clear;
  logic                     hdr_valid;
  falafel_pkg::header_t     hdr;
  falafel_pkg::fit_result_t fit;
  falafel_pkg::write_plan_t plan;

  alloc_req_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_size_i  (req_size_i),
    .accept_i    (accept),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid)
  );

  lsu_sequencer u_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (req_valid_i),
    .cmd_i        (cmd),
    .cmd_valid_i  (cmd_valid),
    .fit_i        (fit),
    .plan_i       (plan),
    .lsu_ready_i  (lsu_ready_i),
    .rsp_i        (rsp_from_lsu_i),
    .accept_o     (accept),
    .core_ready_o (core_ready_o),
    .req_o        (req_to_lsu_o),
    .walk_clear_o (walk_clear),
    .hdr_valid_o  (hdr_valid),
    .hdr_o        (hdr),
    .done_o       (done_o),
    .alloc_addr_o (alloc_addr_o)
  );

  fit_search u_fit_search (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (walk_clear),
    .hdr_valid_i (hdr_valid),
    .hdr_i       (hdr),
    .size_i      (cmd.size),
    .fit_o       (fit)
  );

  split_planner u_split_planner (
    .fit_i  (fit),
    .size_i (cmd.size),
    .plan_o (plan)
  );

endmodule

`default_nettype wire

// ==== src.f ====
common/falafel_pkg.sv
source/alloc_req_decode.sv
allocator/fit_search.sv
allocator/split_planner.sv
allocator/lsu_sequencer.sv
source/falafel_core.sv
verif/heap_model.sv
verif/falafel_tb.sv

// ==== verif/falafel_tb.sv ====
`default_nettype none

module falafel_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_REQS    = 40;
  localparam int          CYCLE_LIMIT = NUM_REQS * 200;
  localparam logic [31:0] BASE_ADDR   = 32'h100;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     req_valid;
  logic [31:0]              req_size;
  logic                     core_ready;
  logic                     done;
  logic [31:0]              alloc_addr;
  falafel_pkg::header_req_t lsu_req;
  logic                     lsu_ready;
  falafel_pkg::header_rsp_t lsu_rsp;
  logic                     init_clear;
  logic                     init_we;
  falafel_pkg::header_t     init_hdr;

  int                       seed;
  int                       errors;
  int                       cycles;
  falafel_pkg::header_t     exp_mem [logic [31:0]];
  falafel_pkg::header_req_t seen_q [$];
  falafel_pkg::header_req_t exp_q [$];

  falafel_core uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_size_i     (req_size),
    .core_ready_o   (core_ready),
    .done_o         (done),
    .alloc_addr_o   (alloc_addr),
    .req_to_lsu_o   (lsu_req),
    .lsu_ready_i    (lsu_ready),
    .rsp_from_lsu_i (lsu_rsp)
  );

  heap_model #(.SEED(29)) u_heap (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_i        (lsu_req),
    .ready_o      (lsu_ready),
    .rsp_o        (lsu_rsp),
    .init_clear_i (init_clear),
    .init_we_i    (init_we),
    .init_hdr_i   (init_hdr)
  );

  always #10 clk = ~clk;

  always @(negedge clk) begin
    if (rst_n && lsu_req.val && lsu_ready) begin
      seen_q.push_back(lsu_req);  // transfer on the next rising edge
    end
  end

  task automatic next_drive();
    @(posedge clk);
    #2;
  endtask

  task automatic expect_xfer(input falafel_pkg::lsu_op_e op, input falafel_pkg::header_t h);
    falafel_pkg::header_req_t r;
    r.val    = 1'b1;
    r.lsu_op = op;
    r.header = h;
    exp_q.push_back(r);
  endtask

  // fields that a request of this op actually defines
  function automatic falafel_pkg::header_req_t defined_fields(input falafel_pkg::header_req_t r);
    if (r.lsu_op == falafel_pkg::LOCK || r.lsu_op == falafel_pkg::UNLOCK) begin
      r.header = '0;
    end else if (r.lsu_op == falafel_pkg::LOAD) begin
      r.header.size      = '0;
      r.header.next_addr = '0;
    end else if (r.lsu_op == falafel_pkg::EDIT_NEXT_ADDR) begin
      r.header.size = '0;
    end
    return r;
  endfunction

  task automatic pick_size(output logic [31:0] size);
    int r;
    r = int'($unsigned($random(seed)) % 16);
    if (r == 0) begin
      size = '0;
    end else if (r == 1) begin
      size = 32'hFFFF_FFFD;  // rounds past the top
    end else begin
      size = 32'd1 + $unsigned($random(seed)) % 32'd280;
    end
  endtask

  task automatic build_heap();
    int                   n;
    int                   i;
    logic [31:0]          addr;
    logic [31:0]          size;
    logic [31:0]          next;
    falafel_pkg::header_t hdrs [$];
    n    = 1 + int'($unsigned($random(seed)) % 6);
    addr = BASE_ADDR;
    hdrs.push_back({falafel_pkg::HEAD_ADDR, 32'd0, BASE_ADDR});
    for (i = 0; i < n; i++) begin
      size = falafel_pkg::ALLOC_ALIGN * (32'd1 + $unsigned($random(seed)) % 32'd32);
      next = addr + falafel_pkg::HEADER_SIZE + size
           + 32'd16 * ($unsigned($random(seed)) % 32'd4);  // random gap
      if (i == n - 1) begin
        next = '0;
      end
      hdrs.push_back({addr, size, next});
      addr = next;
    end
    exp_mem.delete();
    init_clear = 1'b1;
    next_drive();
    init_clear = 1'b0;
    init_we    = 1'b1;
    foreach (hdrs[j]) begin
      exp_mem[hdrs[j].addr] = hdrs[j];
      init_hdr = hdrs[j];
      next_drive();
    end
    init_we = 1'b0;
  endtask

  task automatic predict(input logic [31:0] raw, output logic [31:0] exp_addr);
    logic [63:0]          align;
    logic [63:0]          rounded;
    logic [31:0]          size;
    logic [31:0]          a;
    logic                 found;
    falafel_pkg::header_t cur;
    falafel_pkg::header_t prev;
    falafel_pkg::header_t best;
    falafel_pkg::header_t best_prev;
    falafel_pkg::header_t new_h;
    exp_q.delete();
    exp_addr = '0;
    align    = {32'd0, falafel_pkg::ALLOC_ALIGN};
    rounded  = ({32'd0, raw} + align - 64'd1) / align * align;
    size     = rounded[31:0];
    if (raw == '0 || rounded[63:32] != '0) begin
      return;  // rejected without LSU traffic
    end
    expect_xfer(falafel_pkg::LOCK, '0);
    found     = 1'b0;
    prev      = '0;
    best      = '0;
    best_prev = '0;
    a         = falafel_pkg::HEAD_ADDR;
    do begin
      cur = exp_mem[a];
      expect_xfer(falafel_pkg::LOAD, {a, 32'd0, 32'd0});
      if (cur.size >= size && (!found || cur.size - size < best.size - size)) begin
        found     = 1'b1;
        best      = cur;
        best_prev = prev;
      end
      prev = cur;
      a    = cur.next_addr;
    end while (a != '0);
    if (found) begin
      exp_addr      = best.addr;
      cur           = exp_mem[best_prev.addr];
      cur.next_addr = best.next_addr;
      if ({32'd0, best.size} >= {32'd0, size} + {32'd0, falafel_pkg::HEADER_SIZE}
          + {32'd0, falafel_pkg::MIN_ALLOC_SIZE}) begin
        new_h = {best.addr + falafel_pkg::HEADER_SIZE + size,
                 best.size - size - falafel_pkg::HEADER_SIZE, best.next_addr};
        exp_mem[best.addr]  = {best.addr, size, 32'd0};
        exp_mem[new_h.addr] = new_h;
        expect_xfer(falafel_pkg::EDIT_SIZE_AND_NEXT_ADDR, exp_mem[best.addr]);
        expect_xfer(falafel_pkg::EDIT_SIZE_AND_NEXT_ADDR, new_h);
        cur.next_addr = new_h.addr;
      end
      exp_mem[cur.addr] = cur;
      expect_xfer(falafel_pkg::EDIT_NEXT_ADDR, cur);
    end
    expect_xfer(falafel_pkg::UNLOCK, '0);
  endtask

  task automatic check_request(input string name, input int base, input logic [31:0] exp_addr);
    int n;
    int i;
    assert (alloc_addr == exp_addr) else begin
      errors++;
      $display("FAIL %s alloc_addr: expected %h, actual %h", name, exp_addr, alloc_addr);
    end
    n = seen_q.size() - base;
    assert (n == exp_q.size()) else begin
      errors++;
      $display("FAIL %s transfer count: expected %0d, actual %0d", name, exp_q.size(), n);
    end
    for (i = 0; i < n && i < exp_q.size(); i++) begin
      assert (defined_fields(seen_q[base + i]) == defined_fields(exp_q[i])) else begin
        errors++;
        $display("FAIL %s transfer %0d: expected %h, actual %h",
                 name, i, exp_q[i], seen_q[base + i]);
      end
    end
    assert (u_heap.mem.num() == exp_mem.num()) else begin
      errors++;
      $display("FAIL %s header count: expected %0d, actual %0d",
               name, exp_mem.num(), u_heap.mem.num());
    end
    foreach (exp_mem[k]) begin
      assert (u_heap.mem.exists(k) && u_heap.mem[k] == exp_mem[k]) else begin
        errors++;
        $display("FAIL %s header %h: expected %h, actual %h", name, k, exp_mem[k], u_heap.mem[k]);
      end
    end
  endtask

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("errors: %0d", errors + 1);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int          t;
    int          base;
    logic [31:0] exp_addr;
    string       name;
    seed       = 29;
    errors     = 0;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_size   = '0;
    init_clear = 1'b0;
    init_we    = 1'b0;
    init_hdr   = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    assert ({core_ready, done, lsu_req.val} == 3'b100) else begin
      errors++;
      $display("FAIL reset ready/done/val: expected 100, actual %b",
               {core_ready, done, lsu_req.val});
    end
    for (t = 0; t < NUM_REQS; t++) begin
      name = $sformatf("req%0d", t);
      build_heap();
      pick_size(req_size);
      predict(req_size, exp_addr);
      base      = seen_q.size();
      req_valid = 1'b1;
      next_drive();  // core idles here so the request is taken on this edge
      req_valid = 1'b0;
      do begin
        @(negedge clk);
        assert (!core_ready) else begin
          errors++;
          $display("FAIL %s core_ready while busy: expected 0, actual %b", name, core_ready);
        end
      end while (!done);
      check_request(name, base, exp_addr);
      next_drive();
      assert ({core_ready, done} == 2'b10) else begin
        errors++;
        $display("FAIL %s ready/done after done: expected 10, actual %b",
                 name, {core_ready, done});
      end
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verif/heap_model.sv ====
`default_nettype none

module heap_model #(
  parameter int SEED = 29
) (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire falafel_pkg::header_req_t req_i,
  output logic                          ready_o,
  output falafel_pkg::header_rsp_t      rsp_o,
  input  wire logic                     init_clear_i,
  input  wire logic                     init_we_i,
  input  wire falafel_pkg::header_t     init_hdr_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // heap headers by address
  falafel_pkg::header_t mem [logic [falafel_pkg::DATA_W-1:0]];

  int                   seed;
  int                   wait_cnt;
  logic                 busy;
  falafel_pkg::header_t rsp_hdr;

  task automatic apply_req(input falafel_pkg::header_req_t r);
    falafel_pkg::header_t h;
    case (r.lsu_op)
      falafel_pkg::LOAD: begin
        rsp_hdr = mem.exists(r.header.addr) ? mem[r.header.addr] : '0;
      end
      falafel_pkg::EDIT_SIZE_AND_NEXT_ADDR: begin
        mem[r.header.addr] = r.header;
      end
      falafel_pkg::EDIT_NEXT_ADDR: begin
        h = mem.exists(r.header.addr) ? mem[r.header.addr] : r.header;
        h.next_addr = r.header.next_addr;  // size stays as stored
        mem[r.header.addr] = h;
      end
      default: rsp_hdr = '0;  // lock and unlock carry no data
    endcase
  endtask

  initial begin
    seed     = SEED;
    wait_cnt = 0;
    busy     = 1'b0;
    rsp_hdr  = '0;
    ready_o  = 1'b0;
    rsp_o    = '0;
    forever begin
      // what is seen here is what the next rising edge takes
      @(negedge clk_i);
      if (!rst_ni) begin
        busy = 1'b0;
      end else if (busy) begin
        if (wait_cnt == 1) begin
          busy = 1'b0;  // response taken on the coming edge
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end else if (req_i.val && ready_o) begin
        apply_req(req_i);
        busy     = 1'b1;
        wait_cnt = 1 + int'($unsigned($random(seed)) % 3);
      end
      if (init_clear_i) begin
        mem.delete();
      end
      if (init_we_i) begin
        mem[init_hdr_i.addr] = init_hdr_i;
      end
      @(posedge clk_i);
      #2;
      ready_o      = ($unsigned($random(seed)) % 4) != 0;  // ready about 3 in 4
      rsp_o.val    = busy && (wait_cnt == 1);
      rsp_o.header = rsp_o.val ? rsp_hdr : '0;
    end
  end

endmodule

`default_nettype wire
